// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -Wno-fatal -j 0
TOP ?= istream_tb
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir

.PHONY: all compile run clean

all: run

# Build the simulation binary
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Run it and decide on the printed result
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

// File: bench/istream_tb.sv
`timescale 1ns/1ps

module istream_tb;

	logic CLK;
	logic nRST;

	// DUT inputs
	logic next_valid_SENQ;
	logic [istream_pkg::FETCH_PARCELS-1:0] next_valid_by_fetch_2B_SENQ;
	logic [istream_pkg::FETCH_PARCELS-1:0] next_one_hot_redirect_by_fetch_2B_SENQ;
	logic [istream_pkg::FETCH_PARCELS-1:0][istream_pkg::PARCEL_WIDTH-1:0]
		next_instr_2B_by_fetch_2B_SENQ;
	logic [istream_pkg::PC_WIDTH-1:0] next_PC_SENQ;
	logic next_page_fault_SENQ;
	logic next_stall_SDEQ;
	logic next_restart;
	logic [istream_pkg::PC_WIDTH-1:0] next_restart_PC;

	// DUT outputs
	logic last_stall_SENQ;
	logic last_valid_SDEQ;
	logic [istream_pkg::DEQ_WAYS-1:0] last_valid_by_way_SDEQ;
	logic [istream_pkg::DEQ_WAYS-1:0] last_uncompressed_by_way_SDEQ;
	logic [istream_pkg::DEQ_WAYS-1:0][istream_pkg::INSTR_WIDTH-1:0] last_instr_by_way_SDEQ;
	logic [istream_pkg::DEQ_WAYS-1:0][istream_pkg::PC_WIDTH-1:0] last_PC_by_way_SDEQ;
	logic [istream_pkg::DEQ_WAYS-1:0] last_redirect_by_way_SDEQ;
	logic [istream_pkg::DEQ_WAYS-1:0] last_page_fault_by_way_SDEQ;

	// Reference model, one entry per sent valid parcel
	logic [istream_pkg::PARCEL_WIDTH-1:0] q_instr [$];
	logic [istream_pkg::PC_WIDTH-1:0] q_pc [$];
	logic q_redirect [$];
	logic q_fault [$];

	logic [31:0] rng;
	logic [istream_pkg::PC_WIDTH-1:0] pc_next;
	logic stall_seen;
	// next_stall_SDEQ of this cycle and the two before
	logic stall_now;
	logic stall_prev;
	logic stall_prev2;
	int discard;
	int err_count;
	int test_errors;
	int instr_count;
	int test_instrs;
	int test_count;
	int waited;

	tb_clock i_clock (
		.CLK(CLK),
		.nRST(nRST)
	);

	istream_wrapper i_dut (.*);

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_value(input string what, input int way, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("ERR %0t ns: way %0d %s is %h, expected %h", $time, way, what, got,
				expected);
			err_count++;
			test_errors++;
		end
	endtask

	task automatic note_failure(input string what);
		$display("At %0t ns %s", $time, what);
		err_count++;
		test_errors++;
	endtask

	task automatic abort_run(input string reason);
		$display("Timeout: %s", reason);
		$display(">>> FAIL");
		$finish;
	endtask

	// --------------------
	// Model

	// Next instruction from the model head, by length and fault rules
	task automatic pop_expected(output logic ok, output logic [31:0] instr,
		output logic [31:0] pc, output logic unc, output logic redirect, output logic fault);
		logic [istream_pkg::PARCEL_WIDTH-1:0] lo;
		logic [istream_pkg::PARCEL_WIDTH-1:0] hi;

		ok = 1'b0;
		unc = 1'b0;
		if (q_instr.size() == 0) begin
			note_failure("the DUT delivered an instruction that was never sent");
			return;
		end
		lo = q_instr.pop_front();
		pc = q_pc.pop_front();
		redirect = q_redirect.pop_front();
		fault = q_fault.pop_front();
		instr = {16'h0000, lo};
		if (!fault && (lo[1:0] == 2'b11)) begin
			if (q_instr.size() == 0) begin
				note_failure("the DUT delivered a 32-bit instruction with no upper parcel sent");
				return;
			end
			hi = q_instr.pop_front();
			void'(q_pc.pop_front());
			redirect = q_redirect.pop_front();
			fault = fault | q_fault.pop_front();
			instr = {hi, lo};
			unc = 1'b1;
		end
		ok = 1'b1;
	endtask

	// --------------------
	// Per cycle sampling and driving

	task automatic sample_outputs();
		logic [31:0] exp_instr;
		logic [31:0] exp_pc;
		logic exp_unc;
		logic exp_redirect;
		logic exp_fault;
		logic ok;

		stall_seen = last_stall_SENQ;
		if (discard > 0) begin
			discard--;
		end
		else if (last_valid_SDEQ && !stall_prev2) begin
			// Core output of the last cycle, taken by decode
			for (int w = 0; w < istream_pkg::DEQ_WAYS; w++) begin
				if (last_valid_by_way_SDEQ[w]) begin
					pop_expected(ok, exp_instr, exp_pc, exp_unc, exp_redirect, exp_fault);
					if (ok) begin
						check_value("instr", w, last_instr_by_way_SDEQ[w], exp_instr);
						check_value("PC", w, last_PC_by_way_SDEQ[w], exp_pc);
						check_value("uncompressed", w, 32'(last_uncompressed_by_way_SDEQ[w]),
							32'(exp_unc));
						check_value("redirect", w, 32'(last_redirect_by_way_SDEQ[w]),
							32'(exp_redirect));
						check_value("page fault", w, 32'(last_page_fault_by_way_SDEQ[w]),
							32'(exp_fault));
						instr_count++;
						test_instrs++;
					end
				end
			end
		end
	endtask

	task automatic drive_inputs(input bit allow_send, input bit mixed, input bit flags,
		input bit backpressure, input bit closing, input bit do_restart, output bit sent);
		logic [istream_pkg::FETCH_PARCELS-1:0][istream_pkg::PARCEL_WIDTH-1:0] parcels;
		logic [istream_pkg::FETCH_PARCELS-1:0] mask;
		logic [istream_pkg::FETCH_PARCELS-1:0] redirect;
		logic fault;

		sent = 1'b0;
		stall_prev2 = stall_prev;
		stall_prev = stall_now;
		rng = xorshift32(rng);
		stall_now = backpressure && rng[0];
		next_stall_SDEQ <= stall_now;
		next_restart <= do_restart;
		if (do_restart) begin
			// Everything sent so far is flushed
			q_instr.delete();
			q_pc.delete();
			q_redirect.delete();
			q_fault.delete();
			discard = 3;
			pc_next = {rng[31:1], 1'b0};
			next_restart_PC <= {rng[31:1], 1'b0};
		end

		rng = xorshift32(rng);
		if (allow_send && !do_restart && !stall_seen && (closing || (rng[1:0] != 2'b00))) begin
			mask = closing ? '1 : rng[7:4];
			fault = flags && (rng[9:8] == 2'b00);
			redirect = (flags && rng[10]) ? istream_pkg::FETCH_PARCELS'(1) << rng[12:11] : '0;
			for (int i = 0; i < istream_pkg::FETCH_PARCELS; i++) begin
				rng = xorshift32(rng);
				parcels[i] = rng[15:0];
				// Bias toward 32-bit starts in mixed streams
				if (mixed && rng[16]) begin
					parcels[i][1:0] = 2'b11;
				end
				if (!mixed && (parcels[i][1:0] == 2'b11)) begin
					parcels[i][0] = 1'b0;
				end
				if (mask[i]) begin
					q_instr.push_back(parcels[i]);
					q_pc.push_back(pc_next + istream_pkg::PC_WIDTH'(2 * i));
					q_redirect.push_back(redirect[i]);
					q_fault.push_back(fault);
				end
			end
			next_valid_SENQ <= 1'b1;
			next_valid_by_fetch_2B_SENQ <= mask;
			next_one_hot_redirect_by_fetch_2B_SENQ <= redirect;
			next_instr_2B_by_fetch_2B_SENQ <= parcels;
			next_PC_SENQ <= pc_next;
			next_page_fault_SENQ <= fault;
			pc_next = pc_next + istream_pkg::PC_WIDTH'(2 * istream_pkg::FETCH_PARCELS);
			sent = 1'b1;
		end
		else begin
			next_valid_SENQ <= 1'b0;
		end
	endtask

	task automatic run_cycle(input bit allow_send, input bit mixed, input bit flags,
		input bit backpressure, input bit closing, input bit do_restart, output bit sent);
		@(negedge CLK);
		sample_outputs();
		@(posedge CLK);
		drive_inputs(allow_send, mixed, flags, backpressure, closing, do_restart, sent);
	endtask

	// --------------------
	// Tests

	task automatic run_test(input string name, input int cycles, input bit mixed,
		input bit flags, input bit backpressure, input int restart_at);
		bit sent;
		int tries;

		test_errors = 0;
		test_instrs = 0;
		for (int c = 0; c < cycles; c++) begin
			run_cycle(1'b1, mixed, flags, backpressure, 1'b0, c == restart_at, sent);
		end

		// Compressed packet to complete any dangling 32-bit start
		sent = 1'b0;
		tries = 0;
		while (!sent) begin
			if (tries == 200) begin
				abort_run("the closing packet was never accepted, stall stayed high");
			end
			run_cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, sent);
			tries++;
		end

		tries = 0;
		while (q_instr.size() != 0) begin
			if (tries == 500) begin
				abort_run("sent instructions never came out of the DUT");
			end
			run_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, sent);
			tries++;
		end

		// Idle cycles catch duplicates
		for (int c = 0; c < 6; c++) begin
			run_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, sent);
		end

		test_count++;
		$display("test %s: %0d instructions checked, %0d errors", name, test_instrs,
			test_errors);
	endtask

	initial begin
		next_valid_SENQ <= 1'b0;
		next_valid_by_fetch_2B_SENQ <= '0;
		next_one_hot_redirect_by_fetch_2B_SENQ <= '0;
		next_instr_2B_by_fetch_2B_SENQ <= '0;
		next_PC_SENQ <= '0;
		next_page_fault_SENQ <= 1'b0;
		next_stall_SDEQ <= 1'b0;
		next_restart <= 1'b0;
		next_restart_PC <= '0;
		rng = 32'h65e51115;
		pc_next = 32'h8000_0000;
		stall_seen = 1'b0;
		stall_now = 1'b0;
		stall_prev = 1'b0;
		stall_prev2 = 1'b0;
		discard = 0;
		err_count = 0;
		instr_count = 0;
		test_count = 0;

		waited = 0;
		while (nRST !== 1'b1) begin
			if (waited == 100) begin
				abort_run("reset was never released");
			end
			@(posedge CLK);
			waited++;
		end

		run_test("compressed_only", 300, 1'b0, 1'b0, 1'b0, -1);
		run_test("mixed_lengths", 300, 1'b1, 1'b0, 1'b0, -1);
		run_test("redirect_fault", 300, 1'b1, 1'b1, 1'b0, -1);
		run_test("backpressure", 400, 1'b1, 1'b1, 1'b1, -1);
		run_test("restart", 400, 1'b1, 1'b1, 1'b1, 200);

		$display("tests %0d, instructions %0d, errors %0d", test_count, instr_count,
			err_count);
		if (err_count == 0) begin
			$display(">>> PASS");
		end
		else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic CLK,
	output logic nRST
);

	// 20 ns period
	initial begin
		CLK = 1'b0;
		forever begin
			#10 CLK = ~CLK;
		end
	end

	// Reset held low for the first 16 cycles
	initial begin
		nRST = 1'b0;
		repeat (16) @(posedge CLK);
		nRST <= 1'b1;
	end

endmodule

// File: hdl/istream.sv
`timescale 1ns/1ps

module istream (
	input logic CLK,
	input logic nRST,

	// SENQ stage
	input logic valid_SENQ,
	input logic [istream_pkg::FETCH_PARCELS-1:0] valid_by_fetch_2B_SENQ,
	input logic [istream_pkg::FETCH_PARCELS-1:0] one_hot_redirect_by_fetch_2B_SENQ,
	input logic [istream_pkg::FETCH_PARCELS-1:0][istream_pkg::PARCEL_WIDTH-1:0]
		instr_2B_by_fetch_2B_SENQ,
	input logic [istream_pkg::PC_WIDTH-1:0] PC_SENQ,
	input logic page_fault_SENQ,
	output logic stall_SENQ,

	// SDEQ stage
	output logic valid_SDEQ,
	output logic [istream_pkg::DEQ_WAYS-1:0] valid_by_way_SDEQ,
	output logic [istream_pkg::DEQ_WAYS-1:0] uncompressed_by_way_SDEQ,
	output logic [istream_pkg::DEQ_WAYS-1:0][istream_pkg::INSTR_WIDTH-1:0] instr_by_way_SDEQ,
	output logic [istream_pkg::DEQ_WAYS-1:0][istream_pkg::PC_WIDTH-1:0] PC_by_way_SDEQ,
	output logic [istream_pkg::DEQ_WAYS-1:0] redirect_by_way_SDEQ,
	output logic [istream_pkg::DEQ_WAYS-1:0] page_fault_by_way_SDEQ,
	input logic stall_SDEQ,

	// Restart
	// Each packet brings its own PC and restart_PC has no reader here
	input logic restart,
	input logic [istream_pkg::PC_WIDTH-1:0] restart_PC
);

	// Buffer to aligner
	logic [istream_pkg::WINDOW_PARCELS-1:0] window_valid;
	logic [istream_pkg::WINDOW_PARCELS-1:0][istream_pkg::PARCEL_WIDTH-1:0] window_instr;
	logic [istream_pkg::WINDOW_PARCELS-1:0][istream_pkg::PC_WIDTH-1:0] window_PC;
	logic [istream_pkg::WINDOW_PARCELS-1:0] window_redirect;
	logic [istream_pkg::WINDOW_PARCELS-1:0] window_fault;
	logic [istream_pkg::CONSUME_WIDTH-1:0] consume_count;

	// Aligner to output stage
	logic bundle_ready;
	logic [istream_pkg::DEQ_WAYS-1:0] bundle_valid_by_way;
	logic [istream_pkg::DEQ_WAYS-1:0] bundle_uncompressed_by_way;
	logic [istream_pkg::DEQ_WAYS-1:0][istream_pkg::INSTR_WIDTH-1:0] bundle_instr_by_way;
	logic [istream_pkg::DEQ_WAYS-1:0][istream_pkg::PC_WIDTH-1:0] bundle_PC_by_way;
	logic [istream_pkg::DEQ_WAYS-1:0] bundle_redirect_by_way;
	logic [istream_pkg::DEQ_WAYS-1:0] bundle_fault_by_way;

	istream_buffer i_buffer (.*);

	istream_aligner i_aligner (.*);

	istream_dequeue i_dequeue (.*);

endmodule

// File: hdl/istream_aligner.sv
`timescale 1ns/1ps

module istream_aligner (
	// Head window from the parcel queue
	input logic [istream_pkg::WINDOW_PARCELS-1:0] window_valid,
	input logic [istream_pkg::WINDOW_PARCELS-1:0][istream_pkg::PARCEL_WIDTH-1:0] window_instr,
	input logic [istream_pkg::WINDOW_PARCELS-1:0][istream_pkg::PC_WIDTH-1:0] window_PC,
	input logic [istream_pkg::WINDOW_PARCELS-1:0] window_redirect,
	input logic [istream_pkg::WINDOW_PARCELS-1:0] window_fault,

	// Handshake with the output stage
	input logic bundle_ready,
	output logic [istream_pkg::CONSUME_WIDTH-1:0] consume_count,

	// Bundle toward the output stage
	output logic [istream_pkg::DEQ_WAYS-1:0] bundle_valid_by_way,
	output logic [istream_pkg::DEQ_WAYS-1:0] bundle_uncompressed_by_way,
	output logic [istream_pkg::DEQ_WAYS-1:0][istream_pkg::INSTR_WIDTH-1:0] bundle_instr_by_way,
	output logic [istream_pkg::DEQ_WAYS-1:0][istream_pkg::PC_WIDTH-1:0] bundle_PC_by_way,
	output logic [istream_pkg::DEQ_WAYS-1:0] bundle_redirect_by_way,
	output logic [istream_pkg::DEQ_WAYS-1:0] bundle_fault_by_way
);

	// Parcels that open a 32-bit instruction
	logic [istream_pkg::WINDOW_PARCELS-1:0] long_start;

	// Walk state across the ways
	logic [istream_pkg::CONSUME_WIDTH-1:0] pos;
	logic stop;
	logic [istream_pkg::WINDOW_IDX_WIDTH-1:0] first;
	logic [istream_pkg::WINDOW_IDX_WIDTH-1:0] second;

	// --------------------
	// Length decode

	// A faulting parcel always stands alone, whatever its low bits say
	always_comb begin
		for (int i = 0; i < istream_pkg::WINDOW_PARCELS; i++) begin
			long_start[i] = !window_fault[i] && (window_instr[i][1:0] == 2'b11);
		end
	end

	// --------------------
	// Instruction assembly

	always_comb begin
		pos = '0;
		stop = 1'b0;
		first = '0;
		second = '0;
		bundle_valid_by_way = '0;
		bundle_uncompressed_by_way = '0;
		bundle_instr_by_way = '0;
		bundle_PC_by_way = '0;
		bundle_redirect_by_way = '0;
		bundle_fault_by_way = '0;

		// Way 1 picks up where way 0 stopped
		for (int w = 0; w < istream_pkg::DEQ_WAYS; w++) begin
			if (!stop && (pos < istream_pkg::WINDOW_PARCELS)) begin
				first = pos[istream_pkg::WINDOW_IDX_WIDTH-1:0];
				second = first + istream_pkg::WINDOW_IDX_WIDTH'(1);

				if (!window_valid[first]) begin
					stop = 1'b1;
				end
				else if (!long_start[first]) begin
					// 16-bit instruction, upper half zero
					bundle_valid_by_way[w] = 1'b1;
					bundle_instr_by_way[w] = istream_pkg::INSTR_WIDTH'(window_instr[first]);
					bundle_PC_by_way[w] = window_PC[first];
					bundle_redirect_by_way[w] = window_redirect[first];
					bundle_fault_by_way[w] = window_fault[first];
					pos = pos + istream_pkg::CONSUME_WIDTH'(1);
				end
				else if ((pos < istream_pkg::WINDOW_PARCELS - 1) && window_valid[second]) begin
					// Lower parcel in the low half
					bundle_valid_by_way[w] = 1'b1;
					bundle_uncompressed_by_way[w] = 1'b1;
					bundle_instr_by_way[w] = {window_instr[second], window_instr[first]};
					bundle_PC_by_way[w] = window_PC[first];
					bundle_redirect_by_way[w] = window_redirect[second];
					bundle_fault_by_way[w] = window_fault[first] | window_fault[second];
					pos = pos + istream_pkg::CONSUME_WIDTH'(2);
				end
				else begin
					// Upper half not here yet
					stop = 1'b1;
				end
			end
		end

		consume_count = bundle_ready ? pos : '0;
	end

endmodule

// File: hdl/istream_buffer.sv
`timescale 1ns/1ps

module istream_buffer (
	input logic CLK,
	input logic nRST,
	input logic restart,

	// Fetch side
	input logic valid_SENQ,
	input logic [istream_pkg::FETCH_PARCELS-1:0] valid_by_fetch_2B_SENQ,
	input logic [istream_pkg::FETCH_PARCELS-1:0] one_hot_redirect_by_fetch_2B_SENQ,
	input logic [istream_pkg::FETCH_PARCELS-1:0][istream_pkg::PARCEL_WIDTH-1:0]
		instr_2B_by_fetch_2B_SENQ,
	input logic [istream_pkg::PC_WIDTH-1:0] PC_SENQ,
	input logic page_fault_SENQ,
	output logic stall_SENQ,

	// Head window toward the aligner
	output logic [istream_pkg::WINDOW_PARCELS-1:0] window_valid,
	output logic [istream_pkg::WINDOW_PARCELS-1:0][istream_pkg::PARCEL_WIDTH-1:0] window_instr,
	output logic [istream_pkg::WINDOW_PARCELS-1:0][istream_pkg::PC_WIDTH-1:0] window_PC,
	output logic [istream_pkg::WINDOW_PARCELS-1:0] window_redirect,
	output logic [istream_pkg::WINDOW_PARCELS-1:0] window_fault,
	input logic [istream_pkg::CONSUME_WIDTH-1:0] consume_count
);

	// Parcel storage
	logic [istream_pkg::PARCEL_WIDTH-1:0] instr_q [istream_pkg::QUEUE_PARCELS];
	logic [istream_pkg::PC_WIDTH-1:0] PC_q [istream_pkg::QUEUE_PARCELS];
	logic redirect_q [istream_pkg::QUEUE_PARCELS];
	logic fault_q [istream_pkg::QUEUE_PARCELS];

	logic [istream_pkg::PTR_WIDTH-1:0] head;
	logic [istream_pkg::PTR_WIDTH-1:0] tail;
	logic [istream_pkg::COUNT_WIDTH-1:0] count;
	logic [istream_pkg::COUNT_WIDTH-1:0] count_next;

	logic [istream_pkg::FETCH_PARCELS-1:0] enq_mask;
	logic [istream_pkg::FETCH_PARCELS-1:0][istream_pkg::PTR_WIDTH-1:0] enq_slot;
	logic [istream_pkg::COUNT_WIDTH-1:0] enq_count;
	logic [istream_pkg::PTR_WIDTH-1:0] win_idx [istream_pkg::WINDOW_PARCELS];

	// --------------------
	// Enqueue compaction

	// Each valid parcel lands right after the valid ones below it
	always_comb begin
		enq_mask = valid_SENQ ? valid_by_fetch_2B_SENQ : '0;
		enq_count = '0;
		for (int i = 0; i < istream_pkg::FETCH_PARCELS; i++) begin
			enq_slot[i] = tail + enq_count[istream_pkg::PTR_WIDTH-1:0];
			enq_count = enq_count + istream_pkg::COUNT_WIDTH'(enq_mask[i]);
		end
	end

	always_ff @(posedge CLK) begin
		for (int i = 0; i < istream_pkg::FETCH_PARCELS; i++) begin
			if (enq_mask[i]) begin
				instr_q[enq_slot[i]] <= instr_2B_by_fetch_2B_SENQ[i];
				PC_q[enq_slot[i]] <= PC_SENQ + istream_pkg::PC_WIDTH'(2 * i);
				redirect_q[enq_slot[i]] <= one_hot_redirect_by_fetch_2B_SENQ[i];
				fault_q[enq_slot[i]] <= page_fault_SENQ;
			end
		end
	end

	// --------------------
	// Occupancy and pointers

	always_comb begin
		if (restart) begin
			count_next = '0;
		end
		else begin
			count_next = count + enq_count - istream_pkg::COUNT_WIDTH'(consume_count);
		end
	end

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end
		else if (restart) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end
		else begin
			head <= head + istream_pkg::PTR_WIDTH'(consume_count);
			tail <= tail + enq_count[istream_pkg::PTR_WIDTH-1:0];
			count <= count_next;
		end
	end

	// Looks at the count after this edge so two more packets still fit
	assign stall_SENQ = count_next > istream_pkg::COUNT_WIDTH'(
		istream_pkg::QUEUE_PARCELS - istream_pkg::STALL_FREE_PARCELS);

	// --------------------
	// Head window

	always_comb begin
		for (int w = 0; w < istream_pkg::WINDOW_PARCELS; w++) begin
			win_idx[w] = head + istream_pkg::PTR_WIDTH'(w);
			window_valid[w] = count > istream_pkg::COUNT_WIDTH'(w);
			window_instr[w] = instr_q[win_idx[w]];
			window_PC[w] = PC_q[win_idx[w]];
			window_redirect[w] = redirect_q[win_idx[w]];
			window_fault[w] = fault_q[win_idx[w]];
		end
	end

endmodule

// File: hdl/istream_dequeue.sv
`timescale 1ns/1ps

module istream_dequeue (
	input logic CLK,
	input logic nRST,
	input logic restart,

	// Bundle from the aligner
	input logic [istream_pkg::DEQ_WAYS-1:0] bundle_valid_by_way,
	input logic [istream_pkg::DEQ_WAYS-1:0] bundle_uncompressed_by_way,
	input logic [istream_pkg::DEQ_WAYS-1:0][istream_pkg::INSTR_WIDTH-1:0] bundle_instr_by_way,
	input logic [istream_pkg::DEQ_WAYS-1:0][istream_pkg::PC_WIDTH-1:0] bundle_PC_by_way,
	input logic [istream_pkg::DEQ_WAYS-1:0] bundle_redirect_by_way,
	input logic [istream_pkg::DEQ_WAYS-1:0] bundle_fault_by_way,
	output logic bundle_ready,

	// Decode side
	input logic stall_SDEQ,
	output logic valid_SDEQ,
	output logic [istream_pkg::DEQ_WAYS-1:0] valid_by_way_SDEQ,
	output logic [istream_pkg::DEQ_WAYS-1:0] uncompressed_by_way_SDEQ,
	output logic [istream_pkg::DEQ_WAYS-1:0][istream_pkg::INSTR_WIDTH-1:0] instr_by_way_SDEQ,
	output logic [istream_pkg::DEQ_WAYS-1:0][istream_pkg::PC_WIDTH-1:0] PC_by_way_SDEQ,
	output logic [istream_pkg::DEQ_WAYS-1:0] redirect_by_way_SDEQ,
	output logic [istream_pkg::DEQ_WAYS-1:0] page_fault_by_way_SDEQ
);

	assign valid_SDEQ = |valid_by_way_SDEQ;

	// Free to take a bundle when empty or when decode drains this one
	assign bundle_ready = !valid_SDEQ || !stall_SDEQ;

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			valid_by_way_SDEQ <= '0;
		end
		else if (restart) begin
			valid_by_way_SDEQ <= '0;
		end
		else if (bundle_ready) begin
			valid_by_way_SDEQ <= bundle_valid_by_way;
		end
	end

	// Payload follows the valids, held under stall
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			uncompressed_by_way_SDEQ <= '0;
			instr_by_way_SDEQ <= '0;
			PC_by_way_SDEQ <= '0;
			redirect_by_way_SDEQ <= '0;
			page_fault_by_way_SDEQ <= '0;
		end
		else if (bundle_ready) begin
			uncompressed_by_way_SDEQ <= bundle_uncompressed_by_way;
			instr_by_way_SDEQ <= bundle_instr_by_way;
			PC_by_way_SDEQ <= bundle_PC_by_way;
			redirect_by_way_SDEQ <= bundle_redirect_by_way;
			page_fault_by_way_SDEQ <= bundle_fault_by_way;
		end
	end

endmodule

// File: hdl/istream_pkg.sv
package istream_pkg;

	// Fetch packet and output bundle shape
	localparam int FETCH_PARCELS = 4;
	localparam int DEQ_WAYS = 2;
	localparam int PARCEL_WIDTH = 16;
	localparam int PC_WIDTH = 32;
	localparam int INSTR_WIDTH = 2 * PARCEL_WIDTH;

	// Parcel queue sizing
	localparam int ISTREAM_SETS = 8;
	localparam int QUEUE_PARCELS = ISTREAM_SETS * FETCH_PARCELS;
	localparam int PTR_WIDTH = $clog2(QUEUE_PARCELS);
	localparam int COUNT_WIDTH = PTR_WIDTH + 1;

	// Packets that may still land after stall goes up
	localparam int STALL_MARGIN_PACKETS = 2;
	localparam int STALL_FREE_PARCELS = (STALL_MARGIN_PACKETS + 1) * FETCH_PARCELS;

	// Head window seen by the aligner
	localparam int WINDOW_PARCELS = 4;
	localparam int WINDOW_IDX_WIDTH = $clog2(WINDOW_PARCELS);
	localparam int CONSUME_WIDTH = $clog2(WINDOW_PARCELS + 1);

endpackage

// File: hdl/istream_wrapper.sv
`timescale 1ns/1ps

module istream_wrapper (
	input logic CLK,
	input logic nRST,

	// SENQ stage
	input logic next_valid_SENQ,
	input logic [istream_pkg::FETCH_PARCELS-1:0] next_valid_by_fetch_2B_SENQ,
	input logic [istream_pkg::FETCH_PARCELS-1:0] next_one_hot_redirect_by_fetch_2B_SENQ,
	input logic [istream_pkg::FETCH_PARCELS-1:0][istream_pkg::PARCEL_WIDTH-1:0]
		next_instr_2B_by_fetch_2B_SENQ,
	input logic [istream_pkg::PC_WIDTH-1:0] next_PC_SENQ,
	input logic next_page_fault_SENQ,
	output logic last_stall_SENQ,

	// SDEQ stage
	output logic last_valid_SDEQ,
	output logic [istream_pkg::DEQ_WAYS-1:0] last_valid_by_way_SDEQ,
	output logic [istream_pkg::DEQ_WAYS-1:0] last_uncompressed_by_way_SDEQ,
	output logic [istream_pkg::DEQ_WAYS-1:0][istream_pkg::INSTR_WIDTH-1:0]
		last_instr_by_way_SDEQ,
	output logic [istream_pkg::DEQ_WAYS-1:0][istream_pkg::PC_WIDTH-1:0] last_PC_by_way_SDEQ,
	output logic [istream_pkg::DEQ_WAYS-1:0] last_redirect_by_way_SDEQ,
	output logic [istream_pkg::DEQ_WAYS-1:0] last_page_fault_by_way_SDEQ,
	input logic next_stall_SDEQ,

	// Restart
	input logic next_restart,
	input logic [istream_pkg::PC_WIDTH-1:0] next_restart_PC
);

	// --------------------
	// Core side signals

	logic valid_SENQ;
	logic [istream_pkg::FETCH_PARCELS-1:0] valid_by_fetch_2B_SENQ;
	logic [istream_pkg::FETCH_PARCELS-1:0] one_hot_redirect_by_fetch_2B_SENQ;
	logic [istream_pkg::FETCH_PARCELS-1:0][istream_pkg::PARCEL_WIDTH-1:0]
		instr_2B_by_fetch_2B_SENQ;
	logic [istream_pkg::PC_WIDTH-1:0] PC_SENQ;
	logic page_fault_SENQ;
	logic stall_SENQ;

	logic valid_SDEQ;
	logic [istream_pkg::DEQ_WAYS-1:0] valid_by_way_SDEQ;
	logic [istream_pkg::DEQ_WAYS-1:0] uncompressed_by_way_SDEQ;
	logic [istream_pkg::DEQ_WAYS-1:0][istream_pkg::INSTR_WIDTH-1:0] instr_by_way_SDEQ;
	logic [istream_pkg::DEQ_WAYS-1:0][istream_pkg::PC_WIDTH-1:0] PC_by_way_SDEQ;
	logic [istream_pkg::DEQ_WAYS-1:0] redirect_by_way_SDEQ;
	logic [istream_pkg::DEQ_WAYS-1:0] page_fault_by_way_SDEQ;
	logic stall_SDEQ;

	logic restart;
	logic [istream_pkg::PC_WIDTH-1:0] restart_PC;

	istream i_istream (.*);

	// --------------------
	// Port registers

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			valid_SENQ <= '0;
			valid_by_fetch_2B_SENQ <= '0;
			one_hot_redirect_by_fetch_2B_SENQ <= '0;
			instr_2B_by_fetch_2B_SENQ <= '0;
			PC_SENQ <= '0;
			page_fault_SENQ <= '0;
			last_stall_SENQ <= '0;

			last_valid_SDEQ <= '0;
			last_valid_by_way_SDEQ <= '0;
			last_uncompressed_by_way_SDEQ <= '0;
			last_instr_by_way_SDEQ <= '0;
			last_PC_by_way_SDEQ <= '0;
			last_redirect_by_way_SDEQ <= '0;
			last_page_fault_by_way_SDEQ <= '0;
			stall_SDEQ <= '0;

			restart <= '0;
			restart_PC <= '0;
		end
		else begin
			// Inputs toward the core
			valid_SENQ <= next_valid_SENQ;
			valid_by_fetch_2B_SENQ <= next_valid_by_fetch_2B_SENQ;
			one_hot_redirect_by_fetch_2B_SENQ <= next_one_hot_redirect_by_fetch_2B_SENQ;
			instr_2B_by_fetch_2B_SENQ <= next_instr_2B_by_fetch_2B_SENQ;
			PC_SENQ <= next_PC_SENQ;
			page_fault_SENQ <= next_page_fault_SENQ;
			stall_SDEQ <= next_stall_SDEQ;
			restart <= next_restart;
			restart_PC <= next_restart_PC;

			// Outputs from the core
			last_stall_SENQ <= stall_SENQ;
			last_valid_SDEQ <= valid_SDEQ;
			last_valid_by_way_SDEQ <= valid_by_way_SDEQ;
			last_uncompressed_by_way_SDEQ <= uncompressed_by_way_SDEQ;
			last_instr_by_way_SDEQ <= instr_by_way_SDEQ;
			last_PC_by_way_SDEQ <= PC_by_way_SDEQ;
			last_redirect_by_way_SDEQ <= redirect_by_way_SDEQ;
			last_page_fault_by_way_SDEQ <= page_fault_by_way_SDEQ;
		end
	end

endmodule

// File: tb.f
hdl/istream_pkg.sv
hdl/istream_buffer.sv
hdl/istream_aligner.sv
hdl/istream_dequeue.sv
hdl/istream.sv
hdl/istream_wrapper.sv
bench/tb_clock.sv
bench/istream_tb.sv
